// ==== Bender.yml ====
package:
  name: uart_bridge

sources:
  - source/uart_pkg.sv
  - source/mem_pkg.sv
  - source/uart_rx.sv
  - source/uart_tx.sv
  - source/cmd_engine.sv
  - source/mem_arbiter.sv
  - source/reg_mem.sv
  - source/uart_bridge_top.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/uart_bridge_chk.sv
      - verif/tb_uart_bridge.sv

// ==== source/cmd_engine.sv ====
`default_nettype none

module cmd_engine import uart_pkg::*, mem_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       rx_valid,
	input  logic [7:0] rx_data,
	output mem_req_t   mem_req,
	input  logic       grant,
	input  mem_rsp_t   mem_rsp,
	output logic       tx_valid,
	output logic [7:0] tx_data,
	input  logic       tx_busy
);

	enum logic [2:0] {
		st_wait_cmd,
		st_wait_data,
		st_request,
		st_wait_rsp,
		st_wait_tx
	} state;

	cmd_byte_t  rx_cmd;
	cmd_byte_t  cmd_q;
	logic [7:0] wdata_q;
	logic [7:0] rdata_q;

	assign rx_cmd = cmd_byte_t'(rx_data);

	// The request stays up and stable until the arbiter grants it.
	always_comb begin
		mem_req.valid = (state == st_request);
		mem_req.write = cmd_q.is_write;
		mem_req.addr  = cmd_q.addr;
		mem_req.wdata = wdata_q;
	end

	// A reply goes out as soon as the response lands, unless the transmitter is busy.
	assign tx_valid = !tx_busy &&
		((state == st_wait_rsp && mem_rsp.valid) || state == st_wait_tx);
	assign tx_data = (state == st_wait_tx) ? rdata_q : mem_rsp.rdata;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_wait_cmd;
		end else begin
			case (state)
				st_wait_cmd: begin
					if (rx_valid) begin
						state <= rx_cmd.is_write ? st_wait_data : st_request;
					end
				end
				st_wait_data: begin
					if (rx_valid) begin
						state <= st_request;
					end
				end
				st_request: begin
					if (grant) begin
						state <= cmd_q.is_write ? st_wait_cmd : st_wait_rsp;
					end
				end
				st_wait_rsp: begin
					if (mem_rsp.valid) begin
						state <= tx_busy ? st_wait_tx : st_wait_cmd;
					end
				end
				st_wait_tx: begin
					if (!tx_busy) begin
						state <= st_wait_cmd;
					end
				end
				default: begin
					state <= st_wait_cmd;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_wait_cmd && rx_valid) begin
			cmd_q <= rx_cmd;
		end
		if (state == st_wait_data && rx_valid) begin
			wdata_q <= rx_data;
		end
		if (state == st_wait_rsp && mem_rsp.valid) begin
			rdata_q <= mem_rsp.rdata;
		end
	end

endmodule

`default_nettype wire

// ==== source/mem_arbiter.sv ====
`default_nettype none

module mem_arbiter import mem_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	input  mem_req_t             port_req [num_ports],
	output logic [num_ports-1:0] grant,
	output mem_rsp_t             port_rsp [num_ports],
	output mem_req_t             mem_req,
	input  mem_rsp_t             mem_rsp
);

	logic last_q; // Port of the most recent grant.
	logic sel;
	logic any_req;

	assign any_req = port_req[0].valid || port_req[1].valid;

	// ---------------------------------------------------------------------
	// Selection
	// ---------------------------------------------------------------------

	always_comb begin
		if (port_req[0].valid && port_req[1].valid) begin
			sel = !last_q; // Tie goes to the port that lost last time.
		end else begin
			sel = port_req[1].valid;
		end
	end

	assign mem_req = port_req[sel];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			last_q <= 1'b0;
		end else if (any_req) begin
			last_q <= sel;
		end
	end

	// ---------------------------------------------------------------------
	// Grant and response steering
	// ---------------------------------------------------------------------

	// The memory answers one cycle after the grant, so last_q still names its port.
	always_comb begin
		for (int p = 0; p < num_ports; p++) begin
			grant[p]          = any_req && (sel == p);
			port_rsp[p].valid = mem_rsp.valid && (last_q == p);
			port_rsp[p].rdata = mem_rsp.rdata;
		end
	end

endmodule

`default_nettype wire

// ==== source/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

	localparam int unsigned mem_addr_w = 6;
	localparam int unsigned mem_depth  = 64; // One entry per address.
	localparam int unsigned num_ports  = 2;

	// ---------------------------------------------------------------------
	// Memory bus
	// ---------------------------------------------------------------------

	typedef struct packed {
		logic                  valid;
		logic                  write;
		logic [mem_addr_w-1:0] addr;
		logic [7:0]            wdata;
	} mem_req_t;

	// Only reads produce a response.
	typedef struct packed {
		logic       valid;
		logic [7:0] rdata;
	} mem_rsp_t;

endpackage

`default_nettype wire

// ==== source/reg_mem.sv ====
`default_nettype none

module reg_mem import mem_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  mem_req_t mem_req,
	output mem_rsp_t mem_rsp
);

	logic [7:0] mem [mem_depth];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem     <= '{default: '0};
			mem_rsp <= '0;
		end else begin
			mem_rsp.valid <= mem_req.valid && !mem_req.write; // Writes get no response.
			if (mem_req.valid) begin
				if (mem_req.write) begin
					mem[mem_req.addr] <= mem_req.wdata;
				end else begin
					mem_rsp.rdata <= mem[mem_req.addr];
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/uart_bridge_top.sv ====
`default_nettype none

module uart_bridge_top import mem_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [num_ports-1:0] rx_pin,
	output logic [num_ports-1:0] tx_pin
);

	logic [num_ports-1:0] rx_valid;
	logic [7:0]           rx_data [num_ports];
	logic [num_ports-1:0] tx_valid;
	logic [7:0]           tx_data [num_ports];
	logic [num_ports-1:0] tx_busy;
	logic [num_ports-1:0] grant;
	mem_req_t             port_req [num_ports];
	mem_rsp_t             port_rsp [num_ports];
	mem_req_t             mem_req;
	mem_rsp_t             mem_rsp;

	// One receiver, engine and transmitter per serial port.
	for (genvar p = 0; p < num_ports; p++) begin : g_port
		uart_rx u_rx (
			.clk      (clk),
			.rst_n    (rst_n),
			.rx_pin   (rx_pin[p]),
			.rx_valid (rx_valid[p]),
			.rx_data  (rx_data[p])
		);

		cmd_engine u_engine (
			.clk      (clk),
			.rst_n    (rst_n),
			.rx_valid (rx_valid[p]),
			.rx_data  (rx_data[p]),
			.mem_req  (port_req[p]),
			.grant    (grant[p]),
			.mem_rsp  (port_rsp[p]),
			.tx_valid (tx_valid[p]),
			.tx_data  (tx_data[p]),
			.tx_busy  (tx_busy[p])
		);

		uart_tx u_tx (
			.clk      (clk),
			.rst_n    (rst_n),
			.tx_valid (tx_valid[p]),
			.tx_data  (tx_data[p]),
			.tx_pin   (tx_pin[p]),
			.tx_busy  (tx_busy[p])
		);
	end

	mem_arbiter u_arbiter (
		.clk      (clk),
		.rst_n    (rst_n),
		.port_req (port_req),
		.grant    (grant),
		.port_rsp (port_rsp),
		.mem_req  (mem_req),
		.mem_rsp  (mem_rsp)
	);

	reg_mem u_mem (
		.clk     (clk),
		.rst_n   (rst_n),
		.mem_req (mem_req),
		.mem_rsp (mem_rsp)
	);

endmodule

`default_nettype wire

// ==== source/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

	// ---------------------------------------------------------------------
	// Serial timing
	// ---------------------------------------------------------------------

	localparam int unsigned bit_period = 16; // Clock cycles per serial bit.
	localparam int unsigned cnt_w      = $clog2(bit_period);

	// ---------------------------------------------------------------------
	// Command byte
	// ---------------------------------------------------------------------

	// Bit 7 selects a write. Bit 6 carries nothing and is ignored.
	typedef struct packed {
		logic       is_write;
		logic       unused;
		logic [5:0] addr;
	} cmd_byte_t;

endpackage

`default_nettype wire

// ==== source/uart_rx.sv ====
`default_nettype none

module uart_rx import uart_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       rx_pin,
	output logic       rx_valid,
	output logic [7:0] rx_data
);

	enum logic [1:0] {st_idle, st_start, st_data, st_stop} state;

	logic [2:0]       rx_sync; // Two sync flops plus one more for the edge.
	logic [cnt_w-1:0] cnt;
	logic [2:0]       bit_cnt;
	logic             rx_bit;
	logic             half_end;
	logic             bit_end;

	assign rx_bit   = rx_sync[1];
	assign half_end = (cnt == cnt_w'(bit_period / 2 - 1));
	assign bit_end  = (cnt == cnt_w'(bit_period - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_sync <= '1; // The line idles high.
		end else begin
			rx_sync <= {rx_sync[1:0], rx_pin};
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= st_idle;
			cnt      <= '0;
			bit_cnt  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			cnt      <= cnt + 1'b1;
			case (state)
				st_idle: begin
					cnt <= '0;
					if (rx_sync[2] && !rx_bit) begin
						state <= st_start;
					end
				end
				st_start: begin
					// Check the start bit again at its middle, so a glitch is ignored.
					if (half_end) begin
						cnt   <= '0;
						state <= rx_bit ? st_idle : st_data;
					end
				end
				st_data: begin
					if (bit_end) begin
						cnt     <= '0;
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7) begin
							state <= st_stop;
						end
					end
				end
				st_stop: begin
					if (bit_end) begin
						rx_valid <= rx_bit; // A low stop bit drops the frame.
						state    <= st_idle;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// Bits arrive LSB first and shift in from the top.
	always_ff @(posedge clk) begin
		if (state == st_data && bit_end) begin
			rx_data <= {rx_bit, rx_data[7:1]};
		end
	end

endmodule

`default_nettype wire

// ==== source/uart_tx.sv ====
`default_nettype none

module uart_tx import uart_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       tx_valid,
	input  logic [7:0] tx_data,
	output logic       tx_pin,
	output logic       tx_busy
);

	enum logic [1:0] {st_idle, st_start, st_data, st_stop} state, next_state;

	logic [cnt_w-1:0] cnt;
	logic [2:0]       bit_cnt;
	logic [7:0]       shift;
	logic             bit_end;

	assign bit_end = (cnt == cnt_w'(bit_period - 1));
	assign tx_busy = (state != st_idle);

	always_comb begin
		next_state = state;
		case (state)
			st_idle: begin
				if (tx_valid) begin
					next_state = st_start;
				end
			end
			st_start: begin
				if (bit_end) begin
					next_state = st_data;
				end
			end
			st_data: begin
				if (bit_end && bit_cnt == 3'd7) begin
					next_state = st_stop;
				end
			end
			st_stop: begin
				if (bit_end) begin
					next_state = st_idle; // Stop bit runs its full length.
				end
			end
			default: begin
				next_state = st_idle;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= st_idle;
			cnt     <= '0;
			bit_cnt <= '0;
			tx_pin  <= 1'b1;
		end else begin
			state <= next_state;
			if (state == st_idle || next_state != state || bit_end) begin
				cnt <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end
			if (state != st_data) begin
				bit_cnt <= '0;
			end else if (bit_end) begin
				bit_cnt <= bit_cnt + 1'b1;
			end
			// The pin changes on the same edge as the state it belongs to.
			if (state == st_idle && tx_valid) begin
				tx_pin <= 1'b0;
			end else if (bit_end && next_state == st_data) begin
				tx_pin <= shift[0];
			end else if (next_state == st_stop) begin
				tx_pin <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_idle && tx_valid) begin
			shift <= tx_data;
		end else if (bit_end && next_state == st_data) begin
			shift <= shift >> 1;
		end
	end

endmodule

`default_nettype wire

// ==== sources.f ====
source/uart_pkg.sv
source/mem_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/cmd_engine.sv
source/mem_arbiter.sv
source/reg_mem.sv
source/uart_bridge_top.sv
verif/tb_clk_gen.sv
verif/uart_bridge_chk.sv
verif/tb_uart_bridge.sv

// ==== verif/tb_clk_gen.sv ====
`default_nettype none

module tb_clk_gen (
	output logic clk,
	output logic rst_n
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period.
	end

	initial begin
		rst_n = 1'b0;
		repeat (3) @(posedge clk);
		#1 rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// ==== verif/tb_uart_bridge.sv ====
`default_nettype none

module tb_uart_bridge import uart_pkg::*, mem_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int reply_limit = 40 * bit_period; // Cycles allowed before a reply starts.

	typedef struct packed {
		logic                  port;
		logic [mem_addr_w-1:0] addr;
		logic [7:0]            data;
	} reply_t;

	logic                 clk;
	logic                 rst_n;
	logic [num_ports-1:0] rx_pin;
	logic [num_ports-1:0] tx_pin;

	logic [7:0] model [mem_depth];
	reply_t     replies [$];
	int         errors   = 0;
	int         timeouts = 0;

	tb_clk_gen u_clk_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	uart_bridge_top u_dut (
		.clk    (clk),
		.rst_n  (rst_n),
		.rx_pin (rx_pin),
		.tx_pin (tx_pin)
	);

	// ---------------------------------------------------------------------
	// Reference and checking
	// ---------------------------------------------------------------------

	function automatic logic [7:0] ref_byte(input logic [mem_addr_w-1:0] addr);
		return model[addr];
	endfunction

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic check_value(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("error %s expected 0x%h actual 0x%h", name, expected, actual);
		end
	endtask

	always @(negedge clk) begin : compare
		reply_t rep;
		while (replies.size() > 0) begin
			rep = replies.pop_front();
			check_value($sformatf("tx_pin[%0d] reply for address 0x%h", rep.port, rep.addr),
				ref_byte(rep.addr), rep.data);
		end
	end

	task automatic drain_replies();
		int waited;
		waited = 0;
		while (replies.size() > 0 && waited < 10) begin
			@(negedge clk);
			waited++;
		end
		if (replies.size() > 0) begin
			timeouts++;
			$display("timeout: read replies were never compared");
		end
	endtask

	// ---------------------------------------------------------------------
	// Serial driver and monitor
	// ---------------------------------------------------------------------

	task automatic send_frame(input int p, input logic [7:0] data, input logic stop_bit);
		logic [9:0] frame;
		frame = {stop_bit, data, 1'b0};
		@(posedge clk);
		#1;
		for (int i = 0; i < 10; i++) begin
			rx_pin[p] = frame[i];
			repeat (bit_period) @(posedge clk);
			#1;
		end
		rx_pin[p] = 1'b1;
	endtask

	task automatic recv_byte(input int p, output logic [7:0] data, output logic ok);
		int waited;
		waited = 0;
		ok = 1'b0;
		data = '0;
		while (tx_pin[p] !== 1'b0 && waited < reply_limit) begin
			@(negedge clk);
			waited++;
		end
		if (tx_pin[p] !== 1'b0) begin
			timeouts++;
			$display("timeout: no reply started on tx_pin[%0d] within %0d cycles", p, reply_limit);
			return;
		end
		repeat (bit_period / 2) @(negedge clk); // Middle of the start bit.
		for (int i = 0; i < 8; i++) begin
			repeat (bit_period) @(negedge clk);
			data[i] = tx_pin[p];
		end
		repeat (bit_period) @(negedge clk);
		check_value($sformatf("tx_pin[%0d] stop bit", p), 8'h01, 8'(tx_pin[p]));
		ok = 1'b1;
	endtask

	task automatic write_reg(input int p, input logic [mem_addr_w-1:0] addr,
		input logic [7:0] data, input logic b6);
		cmd_byte_t cmd;
		cmd.is_write = 1'b1;
		cmd.unused   = b6;
		cmd.addr     = addr;
		model[addr]  = data;
		send_frame(p, cmd, 1'b1);
		send_frame(p, data, 1'b1);
	endtask

	// The reply starts before the command frame ends, so the monitor runs alongside.
	task automatic read_reg(input int p, input logic [mem_addr_w-1:0] addr, input logic b6);
		cmd_byte_t  cmd;
		reply_t     rep;
		logic [7:0] data;
		logic       ok;
		cmd.is_write = 1'b0;
		cmd.unused   = b6;
		cmd.addr     = addr;
		fork
			send_frame(p, cmd, 1'b1);
			recv_byte(p, data, ok);
		join
		if (ok) begin
			rep.port = p[0];
			rep.addr = addr;
			rep.data = data;
			replies.push_back(rep);
		end
	endtask

	task automatic issue_cmd(input int p, input logic is_write,
		input logic [mem_addr_w-1:0] addr, input logic [7:0] data, input logic b6);
		if (is_write) begin
			write_reg(p, addr, data, b6);
		end else begin
			read_reg(p, addr, b6);
		end
	endtask

	// ---------------------------------------------------------------------
	// Stimulus
	// ---------------------------------------------------------------------

	initial begin : stimulus
		logic [31:0]           rng;
		logic [mem_addr_w-1:0] a0;
		logic [mem_addr_w-1:0] a1;
		logic [7:0]            d0;
		logic [7:0]            d1;
		cmd_byte_t             bad_cmd;
		int                    waited;
		rx_pin = '1;
		foreach (model[i]) begin
			model[i] = 8'h00;
		end
		rng = 32'd28;
		waited = 0;
		while (rst_n !== 1'b1 && waited < 20) begin
			@(posedge clk);
			waited++;
		end
		if (rst_n !== 1'b1) begin
			timeouts++;
			$display("timeout: reset was never released");
		end

		repeat (20) begin
			@(negedge clk);
			check_value("tx_pin", 8'h03, 8'(tx_pin));
		end
		for (int i = 0; i < 4; i++) begin
			read_reg(0, mem_addr_w'(i * 21), 1'b0);
		end
		drain_replies();

		write_reg(0, 6'h05, 8'ha5, 1'b0);
		read_reg(0, 6'h05, 1'b1);
		write_reg(0, 6'h2a, 8'h3c, 1'b1);
		read_reg(0, 6'h2a, 1'b0);
		drain_replies();

		// Both ports reach the same memory.
		write_reg(1, 6'h10, 8'h81, 1'b0);
		read_reg(0, 6'h10, 1'b0);
		write_reg(0, 6'h11, 8'h7e, 1'b1);
		read_reg(1, 6'h11, 1'b1);
		drain_replies();

		// Frames in the same cycles make the engines request together.
		fork
			write_reg(0, 6'h20, 8'h12, 1'b0);
			write_reg(1, 6'h21, 8'h34, 1'b0);
		join
		fork
			read_reg(0, 6'h20, 1'b0);
			read_reg(1, 6'h21, 1'b1);
		join
		drain_replies();

		for (int r = 0; r < 20; r++) begin
			rng = xorshift32(rng);
			a0 = rng[5:0];
			a1 = rng[13:8];
			d0 = rng[23:16];
			d1 = rng[31:24];
			if (a1 == a0) begin
				a1 = a0 + 1'b1;
			end
			rng = xorshift32(rng);
			fork
				issue_cmd(0, rng[0], a0, d0, rng[2]);
				issue_cmd(1, rng[1], a1, d1, rng[3]);
			join
			drain_replies();
		end

		// A write command with a low stop bit must leave the memory alone.
		bad_cmd.is_write = 1'b1;
		bad_cmd.unused   = 1'b0;
		bad_cmd.addr     = 6'h05;
		send_frame(1, bad_cmd, 1'b0);
		repeat (bit_period) @(posedge clk);
		read_reg(1, 6'h05, 1'b0);
		drain_replies();

		errors += u_dut.u_chk.fail_count;
		$display("errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/uart_bridge_chk.sv ====
`default_nettype none

module uart_bridge_chk import mem_pkg::*; (
	input logic                 clk,
	input logic                 rst_n,
	input logic [num_ports-1:0] grant,
	input mem_req_t             mem_req,
	input mem_rsp_t             mem_rsp,
	input logic [num_ports-1:0] tx_pin,
	input logic [num_ports-1:0] tx_busy
);

	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;

	grant_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(grant))
		else begin
			fail_count++;
			$error("both grant bits are high in one cycle");
		end

	// The memory answers a granted read on the next cycle.
	read_rsp: assert property (@(posedge clk) disable iff (!rst_n)
		(|grant && !mem_req.write) |=> mem_rsp.valid)
		else begin
			fail_count++;
			$error("no response valid one cycle after a read grant");
		end

	tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
		(tx_pin | tx_busy) == '1)
		else begin
			fail_count++;
			$error("tx_pin low while its transmitter is idle");
		end

endmodule

bind uart_bridge_top uart_bridge_chk u_chk (
	.clk     (clk),
	.rst_n   (rst_n),
	.grant   (grant),
	.mem_req (mem_req),
	.mem_rsp (mem_rsp),
	.tx_pin  (tx_pin),
	.tx_busy (tx_busy)
);

`default_nettype wire
